//--- hdl/dcache_geometry_pkg.sv
package dcache_geometry_pkg;

    localparam int ASSOC_NUM      = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_WIDTH     = 32;
    localparam int BLOCK_NUMS     = 256;  // sets per way

    localparam int INDEX_WIDTH  = $clog2(BLOCK_NUMS);                        // 8
    localparam int OFFSET_WIDTH = $clog2(WORDS_PER_LINE * WORD_WIDTH / 8);   // 4
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH;           // 20
    localparam int WSTRB_WIDTH  = WORD_WIDTH / 8;

    typedef logic [31:0]                 addr_t;
    typedef logic [TAG_WIDTH-1:0]        tag_t;
    typedef logic [INDEX_WIDTH-1:0]      index_t;
    typedef logic [OFFSET_WIDTH-1:0]     offset_t;  // byte within line
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [WSTRB_WIDTH-1:0]      wstrb_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] line_t;

    typedef logic [$clog2(ASSOC_NUM)-1:0] way_t;
    typedef logic [ASSOC_NUM-1:0]         way_vec_t;  // one bit per way

endpackage

//--- hdl/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // miss handling, in sequence order
    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } miss_state_t;

endpackage

//--- hdl/dcache_tag_array.sv
`timescale 1ns/10ps

module dcache_tag_array import dcache_geometry_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  index_t   read_index,
    input  tag_t     lookup_tag,
    output way_vec_t hit,
    input  way_t     victim_way,
    output tag_t     victim_tag,
    output logic     victim_dirty,
    input  logic     fill_we,
    input  tag_t     fill_tag,
    input  logic     mark_dirty_we,
    input  way_t     mark_dirty_way,
    input  index_t   mark_dirty_index
);

    tag_t tags [ASSOC_NUM][BLOCK_NUMS];

    logic [ASSOC_NUM-1:0][BLOCK_NUMS-1:0] valid_bits;
    logic [ASSOC_NUM-1:0][BLOCK_NUMS-1:0] dirty_bits;

    always_ff @(posedge clk) begin
        if (fill_we)
            tags[victim_way][read_index] <= fill_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (mark_dirty_we)
                dirty_bits[mark_dirty_way][mark_dirty_index] <= 1'b1;
            // a fresh line is always clean
            if (fill_we) begin
                valid_bits[victim_way][read_index] <= 1'b1;
                dirty_bits[victim_way][read_index] <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            hit[w] = valid_bits[w][read_index] && (tags[w][read_index] == lookup_tag);
        end
    end

    assign victim_tag   = tags[victim_way][read_index];
    assign victim_dirty = dirty_bits[victim_way][read_index];  // invalid lines read clean

    // a fill only ever targets a way that missed, so a tag lives in one way
    hit_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(hit)
    ) else $error("tag found in more than one way");

endmodule

//--- hdl/dcache_data_array.sv
`timescale 1ns/10ps

module dcache_data_array import dcache_geometry_pkg::*; (
    input  logic      clk,
    input  logic      read_en,
    input  index_t    read_index,
    output line_t     rdata [ASSOC_NUM],
    input  logic      fill_we,
    input  way_t      fill_way,
    input  index_t    fill_index,
    input  line_t     fill_line,
    input  logic      word_we,
    input  way_t      word_way,
    input  index_t    word_index,
    input  word_sel_t word_sel,
    input  word_t     word_wdata
);

    word_t mem [ASSOC_NUM][WORDS_PER_LINE][BLOCK_NUMS];

    logic [ASSOC_NUM-1:0]                     fill_en;
    logic [ASSOC_NUM-1:0][WORDS_PER_LINE-1:0] word_en;

    always_comb begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            fill_en[w] = fill_we && (fill_way == way_t'(w));
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                word_en[w][k] = word_we && (word_way == way_t'(w)) &&
                                (word_sel == word_sel_t'(k));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                if (fill_en[w])
                    mem[w][k][fill_index] <= fill_line[k*WORD_WIDTH +: WORD_WIDTH];
                else if (word_en[w][k])
                    mem[w][k][word_index] <= word_wdata;

                // write-first bypass
                if (read_en) begin
                    if (fill_en[w] && fill_index == read_index)
                        rdata[w][k*WORD_WIDTH +: WORD_WIDTH] <=
                            fill_line[k*WORD_WIDTH +: WORD_WIDTH];
                    else if (word_en[w][k] && word_index == read_index)
                        rdata[w][k*WORD_WIDTH +: WORD_WIDTH] <= word_wdata;
                    else
                        rdata[w][k*WORD_WIDTH +: WORD_WIDTH] <= mem[w][k][read_index];
                end
            end
        end
    end

endmodule

//--- hdl/dcache_plru.sv
`timescale 1ns/10ps

module dcache_plru import dcache_geometry_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   touch,
    input  index_t touch_index,
    input  way_t   touch_way,
    input  index_t victim_index,
    output way_t   victim_way
);

    // per set, the way used least recently
    way_t lru [BLOCK_NUMS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < BLOCK_NUMS; s++) begin
                lru[s] <= '0;
            end
        end else if (touch) begin
            lru[touch_index] <= ~touch_way;  // two ways, so the other one
        end
    end

    assign victim_way = lru[victim_index];

endmodule

//--- hdl/dcache_miss_fsm.sv
`timescale 1ns/10ps

module dcache_miss_fsm import dcache_ctrl_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic miss,
    input  logic victim_dirty,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic wr_rdy,
    input  logic wr_valid,
    output logic rd_req,
    output logic wr_req,
    output logic refill_we,
    output logic refill_active,
    output logic refill_done,
    output logic idle
);

    miss_state_t state;
    miss_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset)
            state <= LOOKUP;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (miss)
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
            end
            MISS_DIRTY: begin
                if (wr_rdy)
                    state_next = WRITEBACK;
            end
            WRITEBACK: begin
                // victim must be in memory before the refill is asked for
                if (wr_valid)
                    state_next = MISS_CLEAN;
            end
            MISS_CLEAN: begin
                if (rd_rdy)
                    state_next = REFILL;
            end
            REFILL: begin
                if (ret_valid)
                    state_next = REFILL_DONE;
            end
            REFILL_DONE: begin
                state_next = LOOKUP;
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

    assign wr_req        = (state == MISS_DIRTY);
    assign rd_req        = (state == MISS_CLEAN);
    assign refill_we     = (state == REFILL) && ret_valid;
    assign refill_active = (state == REFILL) || (state == REFILL_DONE);
    assign refill_done   = (state == REFILL_DONE);  // re-read and re-hit
    assign idle          = (state == LOOKUP);

    no_dual_req: assert property (
        @(posedge clk) disable iff (reset) !(rd_req && wr_req)
    ) else $error("refill and writeback requested together");

    // the line read back in REFILL_DONE must now hit, so no second miss follows
    refill_no_remiss: assert property (
        @(posedge clk) disable iff (reset) refill_done |=> !miss
    ) else $error("miss seen right after refill");

endmodule

//--- hdl/dcache.sv
`timescale 1ns/10ps

module dcache import dcache_geometry_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    // pipeline side
    input  logic    data_valid,
    input  logic    data_op,       // 1 = store
    input  tag_t    data_tag,
    input  index_t  data_index,
    input  offset_t data_offset,
    input  word_t   data_wdata,
    input  wstrb_t  data_wstrb,
    output word_t   data_rdata,
    output logic    busy,

    // memory side
    output logic    dcache_rd_req,
    output addr_t   dcache_rd_addr,
    input  logic    dcache_rd_rdy,
    input  logic    dcache_ret_valid,
    input  line_t   dcache_ret_data,
    output logic    dcache_wr_req,
    output addr_t   dcache_wr_addr,
    output line_t   dcache_wr_data,
    input  logic    dcache_wr_rdy,
    input  logic    dcache_wr_valid
);

    logic      req_valid;
    logic      req_op;
    tag_t      req_tag;
    index_t    req_index;
    offset_t   req_offset;
    word_t     req_wdata;
    wstrb_t    req_wstrb;
    word_sel_t req_word;

    way_vec_t  hit;
    way_vec_t  hit_q;
    logic      cache_hit_q;
    logic      hit_done;
    logic      store_hit;
    way_t      hit_way;

    logic      use_req_buf;
    index_t    lookup_index;
    tag_t      lookup_tag;
    way_t      victim_way;
    tag_t      victim_tag;
    logic      victim_dirty;

    line_t     way_line [ASSOC_NUM];
    line_t     hit_line;
    word_t     hit_word;
    word_t     merged_word;

    // store write stage
    logic      st_valid;
    way_t      st_way;
    index_t    st_index;
    word_sel_t st_sel;
    word_t     st_word;

    logic      miss;
    logic      refill_we;
    logic      refill_active;
    logic      refill_done;
    logic      fsm_idle;

    always_ff @(posedge clk) begin
        if (reset)
            req_valid <= 1'b0;
        else if (data_valid)
            req_valid <= 1'b1;
        else if (hit_done)
            req_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            req_op     <= data_op;
            req_tag    <= data_tag;
            req_index  <= data_index;
            req_offset <= data_offset;
            req_wdata  <= data_wdata;
            req_wstrb  <= data_wstrb;
        end
    end

    // registered alongside the data array read
    always_ff @(posedge clk) begin
        if (reset)
            hit_q <= '0;
        else if (data_valid || refill_done)
            hit_q <= hit;
    end

    assign cache_hit_q = |hit_q;
    assign hit_done    = req_valid && fsm_idle && cache_hit_q;
    assign store_hit   = hit_done && req_op;
    assign miss        = req_valid && !cache_hit_q;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (hit_q[w])
                hit_way = way_t'(w);
        end
    end

    // no new request can arrive while busy, so the buffer owns the lookup then
    assign use_req_buf  = refill_active || !data_valid;
    assign lookup_index = use_req_buf ? req_index : data_index;
    assign lookup_tag   = use_req_buf ? req_tag : data_tag;

    assign req_word   = req_offset[OFFSET_WIDTH-1:2];
    assign hit_line   = way_line[hit_way];
    assign hit_word   = hit_line[req_word*WORD_WIDTH +: WORD_WIDTH];
    assign data_rdata = hit_word;

    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < WSTRB_WIDTH; b++) begin
            if (req_wstrb[b])
                merged_word[b*8 +: 8] = req_wdata[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            st_valid <= 1'b0;
        else
            st_valid <= store_hit;
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            st_way   <= hit_way;
            st_index <= req_index;
            st_sel   <= req_word;
            st_word  <= merged_word;
        end
    end

    assign busy = req_valid && (!cache_hit_q || req_op);

    assign dcache_rd_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign dcache_wr_addr = {victim_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign dcache_wr_data = way_line[victim_way];  // set was read with the request

    dcache_tag_array u_tag_array (
        .clk              (clk),
        .reset            (reset),
        .read_index       (lookup_index),
        .lookup_tag       (lookup_tag),
        .hit              (hit),
        .victim_way       (victim_way),
        .victim_tag       (victim_tag),
        .victim_dirty     (victim_dirty),
        .fill_we          (refill_we),
        .fill_tag         (req_tag),
        .mark_dirty_we    (st_valid),
        .mark_dirty_way   (st_way),
        .mark_dirty_index (st_index)
    );

    dcache_data_array u_data_array (
        .clk        (clk),
        .read_en    (data_valid || refill_done),
        .read_index (lookup_index),
        .rdata      (way_line),
        .fill_we    (refill_we),
        .fill_way   (victim_way),
        .fill_index (req_index),
        .fill_line  (dcache_ret_data),
        .word_we    (st_valid),
        .word_way   (st_way),
        .word_index (st_index),
        .word_sel   (st_sel),
        .word_wdata (st_word)
    );

    dcache_plru u_plru (
        .clk          (clk),
        .reset        (reset),
        .touch        (refill_we || hit_done),
        .touch_index  (req_index),
        .touch_way    (refill_we ? victim_way : hit_way),
        .victim_index (req_index),
        .victim_way   (victim_way)
    );

    dcache_miss_fsm u_miss_fsm (
        .clk           (clk),
        .reset         (reset),
        .miss          (miss),
        .victim_dirty  (victim_dirty),
        .rd_rdy        (dcache_rd_rdy),
        .ret_valid     (dcache_ret_valid),
        .wr_rdy        (dcache_wr_rdy),
        .wr_valid      (dcache_wr_valid),
        .rd_req        (dcache_rd_req),
        .wr_req        (dcache_wr_req),
        .refill_we     (refill_we),
        .refill_active (refill_active),
        .refill_done   (refill_done),
        .idle          (fsm_idle)
    );

    no_req_while_busy: assert property (
        @(posedge clk) disable iff (reset) data_valid |-> !busy
    ) else $error("request issued while cache busy");

endmodule

//--- verification/dcache_mem_model.sv
`timescale 1ns/10ps

module dcache_mem_model import dcache_geometry_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output line_t ret_data,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy,
    output logic  wr_valid
);

    line_t lines [addr_t];  // only lines that were written back

    function automatic line_t read_line(addr_t la);
        line_t l;
        if (lines.exists(la))
            return lines[la];
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[k*WORD_WIDTH +: WORD_WIDTH] = (la + addr_t'(4 * k)) ^ 32'ha5a5_0000;
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // rdy after 0 to 7 cycles, data 1 to 8 cycles after rdy
    task automatic serve_refill();
        addr_t la;
        repeat ($urandom_range(7)) next_cycle();
        la = rd_addr;
        rd_rdy = 1'b1;
        next_cycle();
        rd_rdy = 1'b0;
        repeat ($urandom_range(7)) next_cycle();
        ret_valid = 1'b1;
        ret_data  = read_line(la);
        next_cycle();
        ret_valid = 1'b0;
    endtask

    task automatic serve_writeback();
        repeat ($urandom_range(7)) next_cycle();
        lines[wr_addr] = wr_data;
        wr_rdy = 1'b1;
        next_cycle();
        wr_rdy = 1'b0;
        repeat ($urandom_range(7)) next_cycle();
        wr_valid = 1'b1;
        next_cycle();
        wr_valid = 1'b0;
    endtask

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_valid  = 1'b0;
        void'($urandom(32'h3c7));
        forever begin
            next_cycle();
            if (!reset && wr_req)
                serve_writeback();
            else if (!reset && rd_req)
                serve_refill();
        end
    end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb import dcache_geometry_pkg::*; ();

    localparam int    MAX_PATTERNS = 64;
    localparam int    FIELDS       = 5;  // op, addr, wdata, wstrb, expected
    localparam string PATTERN_FILE = "verification/dcache_patterns.txt";

    logic    clk;
    logic    reset;
    logic    data_valid;
    logic    data_op;
    tag_t    data_tag;
    index_t  data_index;
    offset_t data_offset;
    word_t   data_wdata;
    wstrb_t  data_wstrb;
    word_t   data_rdata;
    logic    busy;
    logic    dcache_rd_req;
    addr_t   dcache_rd_addr;
    logic    dcache_rd_rdy;
    logic    dcache_ret_valid;
    line_t   dcache_ret_data;
    logic    dcache_wr_req;
    addr_t   dcache_wr_addr;
    line_t   dcache_wr_data;
    logic    dcache_wr_rdy;
    logic    dcache_wr_valid;

    logic [31:0] patterns [MAX_PATTERNS*FIELDS];
    word_t       shadow [addr_t];  // words touched by stores

    // reference copy of tags, valid, dirty and lru
    tag_t ref_tag   [ASSOC_NUM][BLOCK_NUMS];
    logic ref_valid [ASSOC_NUM][BLOCK_NUMS];
    logic ref_dirty [ASSOC_NUM][BLOCK_NUMS];
    way_t ref_lru   [BLOCK_NUMS];

    logic  exp_miss;
    logic  exp_wb;
    addr_t exp_rd_addr;
    addr_t exp_wr_addr;
    line_t exp_wr_line;
    logic  rd_seen;
    logic  wr_seen;
    int    cycle_count;
    int    timeout_limit;

    dcache u_dut (
        .clk              (clk),
        .reset            (reset),
        .data_valid       (data_valid),
        .data_op          (data_op),
        .data_tag         (data_tag),
        .data_index       (data_index),
        .data_offset      (data_offset),
        .data_wdata       (data_wdata),
        .data_wstrb       (data_wstrb),
        .data_rdata       (data_rdata),
        .busy             (busy),
        .dcache_rd_req    (dcache_rd_req),
        .dcache_rd_addr   (dcache_rd_addr),
        .dcache_rd_rdy    (dcache_rd_rdy),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret_data  (dcache_ret_data),
        .dcache_wr_req    (dcache_wr_req),
        .dcache_wr_addr   (dcache_wr_addr),
        .dcache_wr_data   (dcache_wr_data),
        .dcache_wr_rdy    (dcache_wr_rdy),
        .dcache_wr_valid  (dcache_wr_valid)
    );

    dcache_mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (dcache_rd_req),
        .rd_addr   (dcache_rd_addr),
        .rd_rdy    (dcache_rd_rdy),
        .ret_valid (dcache_ret_valid),
        .ret_data  (dcache_ret_data),
        .wr_req    (dcache_wr_req),
        .wr_addr   (dcache_wr_addr),
        .wr_data   (dcache_wr_data),
        .wr_rdy    (dcache_wr_rdy),
        .wr_valid  (dcache_wr_valid)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_line(string name, line_t actual, line_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, addr_t actual, addr_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic fail_with(string reason);
        $display("%s (at %0t ns)", reason, $time);
        abort_run();
    endtask

    function automatic word_t shadow_word(addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa))
            return shadow[wa];
        return wa ^ 32'ha5a5_0000;  // untouched memory
    endfunction

    function automatic line_t shadow_line(addr_t la);
        line_t l;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[k*WORD_WIDTH +: WORD_WIDTH] = shadow_word(la + addr_t'(4 * k));
        end
        return l;
    endfunction

    // hit or victim choice, updates the reference tags
    task automatic predict_access(addr_t a, logic is_store);
        tag_t   t;
        index_t idx;
        way_t   w;
        logic   found;
        t     = a[31 -: TAG_WIDTH];
        idx   = a[OFFSET_WIDTH +: INDEX_WIDTH];
        found = 1'b0;
        w     = '0;
        for (int i = 0; i < ASSOC_NUM; i++) begin
            if (ref_valid[i][idx] && ref_tag[i][idx] == t) begin
                found = 1'b1;
                w     = way_t'(i);
            end
        end
        exp_miss    = !found;
        exp_wb      = 1'b0;
        exp_rd_addr = {a[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        if (!found) begin
            w           = ref_lru[idx];
            exp_wb      = ref_valid[w][idx] && ref_dirty[w][idx];
            exp_wr_addr = {ref_tag[w][idx], idx, {OFFSET_WIDTH{1'b0}}};
            exp_wr_line = shadow_line(exp_wr_addr);
            ref_tag[w][idx]   = t;
            ref_valid[w][idx] = 1'b1;
            ref_dirty[w][idx] = 1'b0;
        end
        if (is_store)
            ref_dirty[w][idx] = 1'b1;
        ref_lru[idx] = ~w;
    endtask

    // called 1 ns after a rising edge with busy low
    task automatic run_pattern(int p);
        logic   op;
        addr_t  a;
        word_t  wdata;
        wstrb_t strb;
        word_t  expected;
        word_t  merged;
        int     busy_cycles;
        op       = patterns[p*FIELDS][0];
        a        = patterns[p*FIELDS+1];
        wdata    = patterns[p*FIELDS+2];
        strb     = wstrb_t'(patterns[p*FIELDS+3]);
        expected = patterns[p*FIELDS+4];
        predict_access(a, op);
        rd_seen     = 1'b0;
        wr_seen     = 1'b0;
        data_valid  = 1'b1;
        data_op     = op;
        data_tag    = a[31 -: TAG_WIDTH];
        data_index  = a[OFFSET_WIDTH +: INDEX_WIDTH];
        data_offset = a[OFFSET_WIDTH-1:0];
        data_wdata  = wdata;
        data_wstrb  = strb;
        if (op) begin
            merged = shadow_word(a);
            for (int b = 0; b < WSTRB_WIDTH; b++) begin
                if (strb[b])
                    merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
            shadow[{a[31:2], 2'b00}] = merged;
        end
        @(posedge clk);
        #1;
        data_valid  = 1'b0;
        busy_cycles = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            busy_cycles++;
        end
        if (!exp_miss && busy_cycles != int'(op))
            fail_with($sformatf("hit at %h held busy for %0d cycles", a, busy_cycles));
        if (exp_miss && (busy_cycles == 0 || !rd_seen))
            fail_with($sformatf("miss at %h finished without a refill", a));
        if (exp_wb && !wr_seen)
            fail_with($sformatf("dirty victim of %h was never written back", a));
        if (!op) begin
            check_word("data_rdata", data_rdata, expected);
            check_word("data_rdata", data_rdata, shadow_word(a));
        end
    endtask

    // bus requests, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && dcache_rd_req) begin
            if (!exp_miss)
                fail_with("refill request on a cache hit");
            rd_seen = 1'b1;
            check_addr("dcache_rd_addr", dcache_rd_addr, exp_rd_addr);
        end
        if (!reset && dcache_wr_req) begin
            if (!exp_wb)
                fail_with("writeback request without a dirty victim");
            wr_seen = 1'b1;
            check_addr("dcache_wr_addr", dcache_wr_addr, exp_wr_addr);
            check_line("dcache_wr_data", dcache_wr_data, exp_wr_line);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit)
            fail_with($sformatf("timeout after %0d cycles", cycle_count));
    end

    initial begin
        int n;
        clk         = 1'b0;
        reset       = 1'b1;
        data_valid  = 1'b0;
        data_op     = 1'b0;
        data_tag    = '0;
        data_index  = '0;
        data_offset = '0;
        data_wdata  = '0;
        data_wstrb  = '0;
        exp_miss    = 1'b0;
        exp_wb      = 1'b0;
        exp_rd_addr = '0;
        exp_wr_addr = '0;
        exp_wr_line = '0;
        rd_seen     = 1'b0;
        wr_seen     = 1'b0;
        cycle_count = 0;
        for (int i = 0; i < MAX_PATTERNS * FIELDS; i++) begin
            patterns[i] = '1;  // all ones marks the end
        end
        $readmemh(PATTERN_FILE, patterns);
        n = 0;
        while (n < MAX_PATTERNS && patterns[n*FIELDS] !== 32'hffff_ffff)
            n++;
        timeout_limit = n * 40 + 100;
        for (int s = 0; s < BLOCK_NUMS; s++) begin
            ref_lru[s] = '0;
            for (int w = 0; w < ASSOC_NUM; w++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        if (n == 0)
            fail_with("no patterns read from the pattern file");
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (busy || dcache_rd_req || dcache_wr_req)
            fail_with("busy or a bus request active right after reset");
        for (int p = 0; p < n; p++) begin
            run_pattern(p);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- flist.f
hdl/dcache_geometry_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_plru.sv
hdl/dcache_miss_fsm.sv
hdl/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- verification/dcache_patterns.txt
// op addr wdata wstrb expected_load_data, all hex
// op 0 = load, 1 = store; expected is unused for stores
0 00001104 00000000 0 a5a51104
0 0000110c 00000000 0 a5a5110c
1 00001108 11223344 3 00000000
0 00001108 00000000 0 a5a53344
1 0000110c deadbeef 9 00000000
1 00001100 cafef00d f 00000000
0 0000110c 00000000 0 dea511ef
0 00002100 00000000 0 a5a52100
0 00001100 00000000 0 cafef00d
0 00003104 00000000 0 a5a53104
0 00002108 00000000 0 a5a52108
0 00001108 00000000 0 a5a53344
1 00001100 12345678 4 00000000
1 00004204 55aa55aa c 00000000
0 00004204 00000000 0 55aa4204
0 00005200 00000000 0 a5a55200
0 00006200 00000000 0 a5a56200
0 00004204 00000000 0 55aa4204
0 00001100 00000000 0 ca34f00d
0 12345670 00000000 0 b7915670
